/* logic/dspStatusPkg.sv */
`default_nettype none

package dspStatusPkg;

  typedef logic [15:0] dataT;     // ALU operand or result word.
  typedef logic [3:0]  codeT;     // Condition or termination code.
  typedef logic [7:0]  hostDataT;
  typedef logic [1:0]  hostAdrT;

  typedef enum logic [2:0] {
    NOP, ADD, SUB, ABS, PASS, PUSH, POP
  } opKindT;

  typedef struct packed {
    logic az;
    logic an;
    logic av;
    logic ac;
    logic as;
    logic asValid; // Only ABS writes AS.
  } aluFlagsT;

  // ASTAT layout, top bit first.
  typedef struct packed {
    logic ss;
    logic mv;
    logic aq;
    logic as;
    logic ac;
    logic av;
    logic an;
    logic az;
  } astatT;

  typedef struct packed {
    logic     valid;
    opKindT   kind;
    dataT     result;
    aluFlagsT flags;
    codeT     cond;
    codeT     term;
  } eStageT;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    hostAdrT  adr;
    hostDataT dat;
  } hostReqT;

  localparam hostAdrT ADR_ASTAT = 2'd0;
  localparam hostAdrT ADR_CTRL  = 2'd1;
  localparam hostAdrT ADR_STACK = 2'd2;

  localparam codeT EQ     = 4'd0;
  localparam codeT NE     = 4'd1;
  localparam codeT GT     = 4'd2;
  localparam codeT LE     = 4'd3;
  localparam codeT LT     = 4'd4;
  localparam codeT GE     = 4'd5;
  localparam codeT AVS    = 4'd6;
  localparam codeT AVC    = 4'd7;
  localparam codeT ACS    = 4'd8;
  localparam codeT ACC    = 4'd9;
  localparam codeT ASS    = 4'd10;
  localparam codeT ASC    = 4'd11;
  localparam codeT MVS    = 4'd12;
  localparam codeT MVC    = 4'd13;
  localparam codeT CNTX   = 4'd14;
  localparam codeT ALWAYS = 4'd15;

endpackage

`default_nettype wire

/* logic/aluFlagGen.sv */
`timescale 1ns/1ps
`default_nettype none

module aluFlagGen
  import dspStatusPkg::*;
(
  input  logic   DSPCLK,
  input  logic   T_RSTi,
  input  logic   opValid,
  input  opKindT opKind,
  input  dataT   opA,
  input  dataT   opB,
  input  codeT   opCond,
  input  codeT   opTerm,
  output eStageT eStage
);

  logic [16:0] sum;
  logic [16:0] diff;
  dataT        negA;
  dataT        result;
  aluFlagsT    flags;

  assign sum  = {1'b0, opA} + {1'b0, opB};
  assign diff = {1'b0, opA} + {1'b0, ~opB} + 17'd1; // Bit 16 set means no borrow.
  assign negA = ~opA + 16'd1;

  always_comb begin
    result = '0;
    flags  = '0;
    case (opKind)
      ADD: begin
        result   = sum[15:0];
        flags.ac = sum[16];
        flags.av = (opA[15] == opB[15]) && (sum[15] != opA[15]);
      end
      SUB: begin
        result   = diff[15:0];
        flags.ac = diff[16];
        flags.av = (opA[15] != opB[15]) && (diff[15] != opA[15]);
      end
      ABS: begin
        result        = opA[15] ? negA : opA;
        flags.av      = (opA == 16'h8000); // Negating the most negative value overflows.
        flags.as      = opA[15];
        flags.asValid = 1'b1;
      end
      PASS: begin
        result = opA;
      end
      default: begin
        result = '0; // PUSH, POP and NOP carry no result.
      end
    endcase
    if (opKind inside {ADD, SUB, ABS, PASS}) begin
      flags.az = (result == '0);
      flags.an = result[15];
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (T_RSTi) begin
      eStage.valid <= 1'b0;
    end else begin
      eStage.valid <= opValid;
    end
    if (opValid) begin
      eStage.kind   <= opKind;
      eStage.result <= result;
      eStage.flags  <= flags;
      eStage.cond   <= opCond;
      eStage.term   <= opTerm;
    end
  end

endmodule

`default_nettype wire

/* logic/statusStack.sv */
`timescale 1ns/1ps
`default_nettype none

module statusStack
  import dspStatusPkg::*;
#(
  parameter int STACK_DEPTH = 4
) (
  input  logic     DSPCLK,
  input  logic     T_RSTi,
  input  logic     push,
  input  logic     pop,
  input  astatT    pushData,
  output astatT    popData,
  output logic     popValid,
  output hostDataT fill,
  output logic     overflowErr,
  output logic     underflowErr,
  input  logic     clrErr
);

  localparam int CNT_W = $clog2(STACK_DEPTH + 1);
  localparam int IDX_W = $clog2(STACK_DEPTH);

  astatT            mem [STACK_DEPTH];
  logic [CNT_W-1:0] cnt;
  logic [IDX_W-1:0] topIdx;
  logic             full;
  logic             empty;

  assign full     = (cnt == CNT_W'(STACK_DEPTH));
  assign empty    = (cnt == '0);
  assign topIdx   = IDX_W'(cnt - 1'b1);
  assign popData  = mem[topIdx];
  assign popValid = pop && !empty;  // An empty pop leaves ASTAT alone.
  assign fill     = hostDataT'(cnt);

  always_ff @(posedge DSPCLK) begin
    if (push && !full) begin
      mem[IDX_W'(cnt)] <= pushData;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (T_RSTi) begin
      cnt          <= '0;
      overflowErr  <= 1'b0;
      underflowErr <= 1'b0;
    end else begin
      if (clrErr) begin
        overflowErr  <= 1'b0;
        underflowErr <= 1'b0;
      end
      if (push) begin
        if (full) overflowErr <= 1'b1;
        else cnt <= cnt + 1'b1;
      end else if (pop) begin
        if (empty) underflowErr <= 1'b1;
        else cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/astatHostRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module astatHostRegs
  import dspStatusPkg::*;
(
  input  logic     DSPCLK,
  input  logic     T_RSTi,
  input  hostReqT  hostReq,
  output hostDataT wbDatR,
  output logic     wbAck,
  input  astatT    astat,
  input  logic     busyE,
  input  hostDataT fill,
  input  logic     overflowErr,
  input  logic     underflowErr,
  output logic     hostWrAstat,
  output astatT    hostAstat,
  output logic     stickyAv,
  output logic     stackClrErr
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    ACK
  } hostStateT;

  hostStateT state;
  logic      accept;
  hostDataT  rdData;

  assign accept      = (state == IDLE) && hostReq.cyc && hostReq.stb;
  assign stackClrErr = accept && hostReq.we && (hostReq.adr == ADR_STACK) && hostReq.dat[0];
  assign hostWrAstat = (state == WAIT) && !busyE; // Wait for the E stage to drain.
  assign hostAstat   = astatT'(hostReq.dat);      // Host keeps dat stable until ack.
  assign wbAck       = (state == ACK);

  always_comb begin
    case (hostReq.adr)
      ADR_ASTAT: rdData = astat;
      ADR_CTRL:  rdData = {7'd0, stickyAv};
      ADR_STACK: rdData = {underflowErr, overflowErr, 2'b00, fill[3:0]};
      default:   rdData = '0;
    endcase
  end

  always_ff @(posedge DSPCLK) begin
    if (accept && !hostReq.we) begin
      wbDatR <= rdData;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (T_RSTi) begin
      state    <= IDLE;
      stickyAv <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            if (hostReq.we && (hostReq.adr == ADR_ASTAT)) begin
              state <= WAIT;
            end else begin
              state <= ACK;
            end
            if (hostReq.we && (hostReq.adr == ADR_CTRL)) begin
              stickyAv <= hostReq.dat[0];
            end
          end
        end
        WAIT: begin
          if (hostWrAstat) state <= ACK; // ASTAT is written at this edge.
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/condUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module condUnit
  import dspStatusPkg::*;
(
  input  logic   DSPCLK,
  input  logic   T_RSTi,
  input  eStageT eStage,
  input  logic   hostWrAstat,
  input  astatT  hostAstat,
  input  logic   stickyAv,
  input  astatT  popData,
  input  logic   popValid,
  output logic   push,
  output logic   pop,
  output astatT  astat,
  output logic   busyE,
  output logic   resValid,
  output dataT   resData,
  output logic   condOk,
  output logic   termOk
);

  astatT astatQ;
  astatT aluAstat;
  astatT astatNext;
  logic  isAlu;
  logic  condNext;
  logic  termNext;

  // True when the code holds for the given status.
  function automatic logic condTrue(codeT code, astatT s);
    logic lt;
    lt = s.an ^ s.av;
    case (code)
      EQ:      condTrue = s.az;
      NE:      condTrue = !s.az;
      GT:      condTrue = !(lt || s.az);
      LE:      condTrue = lt || s.az;
      LT:      condTrue = lt;
      GE:      condTrue = !lt;
      AVS:     condTrue = s.av;
      AVC:     condTrue = !s.av;
      ACS:     condTrue = s.ac;
      ACC:     condTrue = !s.ac;
      ASS:     condTrue = s.as;
      ASC:     condTrue = !s.as;
      MVS:     condTrue = s.mv;
      MVC:     condTrue = !s.mv;
      CNTX:    condTrue = 1'b0; // No loop counter here, so it never expires.
      default: condTrue = 1'b1;
    endcase
  endfunction

  assign isAlu = eStage.valid && (eStage.kind inside {ADD, SUB, ABS, PASS});
  assign push  = eStage.valid && (eStage.kind == PUSH);
  assign pop   = eStage.valid && (eStage.kind == POP);
  assign busyE = eStage.valid;
  assign astat = astatQ;

  always_comb begin
    aluAstat    = astatQ;
    aluAstat.az = eStage.flags.az;
    aluAstat.an = eStage.flags.an;
    aluAstat.ac = eStage.flags.ac;
    aluAstat.av = eStage.flags.av || (stickyAv && astatQ.av); // Sticky overflow mode.
    if (eStage.flags.asValid) begin
      aluAstat.as = eStage.flags.as;
    end
  end

  // Pop beats a host write, which beats the ALU.
  always_comb begin
    if (popValid) begin
      astatNext = popData;
    end else if (hostWrAstat) begin
      astatNext = hostAstat;
    end else if (isAlu) begin
      astatNext = aluAstat;
    end else begin
      astatNext = astatQ;
    end
  end

  assign condNext = condTrue(eStage.cond, astatNext);
  // The termination code is tested as a condition and inverted, but ALWAYS never terminates.
  assign termNext = (eStage.term == ALWAYS) ? 1'b0 : !condTrue(eStage.term, astatNext);

  always_ff @(posedge DSPCLK) begin
    if (T_RSTi) begin
      astatQ   <= '0;
      resValid <= 1'b0;
      condOk   <= 1'b0;
      termOk   <= 1'b0;
    end else begin
      astatQ   <= astatNext;
      resValid <= eStage.valid;
      condOk   <= eStage.valid && condNext;
      termOk   <= eStage.valid && termNext;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (eStage.valid) begin
      resData <= eStage.result;
    end
  end

endmodule

`default_nettype wire

/* logic/dspStatusTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dspStatusTop
  import dspStatusPkg::*;
#(
  parameter int STACK_DEPTH = 4
) (
  input  logic     DSPCLK,
  input  logic     T_RSTi,
  input  logic     opValid,
  input  opKindT   opKind,
  input  dataT     opA,
  input  dataT     opB,
  input  codeT     opCond,
  input  codeT     opTerm,
  output logic     resValid,
  output dataT     resData,
  output logic     condOk,
  output logic     termOk,
  output astatT    astat,
  input  logic     wbCyc,
  input  logic     wbStb,
  input  logic     wbWe,
  input  hostAdrT  wbAdr,
  input  hostDataT wbDatW,
  output hostDataT wbDatR,
  output logic     wbAck
);

  eStageT   eStage;
  hostReqT  hostReq;
  astatT    popData;
  astatT    hostAstat;
  hostDataT fill;
  logic     push;
  logic     pop;
  logic     popValid;
  logic     overflowErr;
  logic     underflowErr;
  logic     stackClrErr;
  logic     hostWrAstat;
  logic     stickyAv;
  logic     busyE;

  assign hostReq = '{cyc: wbCyc, stb: wbStb, we: wbWe, adr: wbAdr, dat: wbDatW};

  aluFlagGen aluFlagGen0 (
    .DSPCLK(DSPCLK), .T_RSTi(T_RSTi),
    .opValid(opValid), .opKind(opKind), .opA(opA), .opB(opB),
    .opCond(opCond), .opTerm(opTerm), .eStage(eStage)
  );

  condUnit condUnit0 (
    .DSPCLK(DSPCLK), .T_RSTi(T_RSTi), .eStage(eStage),
    .hostWrAstat(hostWrAstat), .hostAstat(hostAstat), .stickyAv(stickyAv),
    .popData(popData), .popValid(popValid), .push(push), .pop(pop),
    .astat(astat), .busyE(busyE), .resValid(resValid), .resData(resData),
    .condOk(condOk), .termOk(termOk)
  );

  statusStack #(.STACK_DEPTH(STACK_DEPTH)) statusStack0 (
    .DSPCLK(DSPCLK), .T_RSTi(T_RSTi), .push(push), .pop(pop),
    .pushData(astat), .popData(popData), .popValid(popValid), .fill(fill),
    .overflowErr(overflowErr), .underflowErr(underflowErr), .clrErr(stackClrErr)
  );

  astatHostRegs astatHostRegs0 (
    .DSPCLK(DSPCLK), .T_RSTi(T_RSTi), .hostReq(hostReq),
    .wbDatR(wbDatR), .wbAck(wbAck), .astat(astat), .busyE(busyE), .fill(fill),
    .overflowErr(overflowErr), .underflowErr(underflowErr),
    .hostWrAstat(hostWrAstat), .hostAstat(hostAstat), .stickyAv(stickyAv),
    .stackClrErr(stackClrErr)
  );

endmodule

`default_nettype wire

/* dv/dspStatusChecks.svh */
`ifndef DSPSTATUSCHECKS_SVH
`define DSPSTATUSCHECKS_SVH

task automatic compareWord(string name, dataT got, dataT exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic compareBit(string name, logic got, logic exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic compareStatus(string name, astatT got, astatT exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic compareByte(string name, hostDataT got, hostDataT exp);
  checkCount++;
  if (got !== exp) begin
    errCount++;
    $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
  end
endtask

// Linear congruential generator, upper bits only.
function automatic logic [15:0] nextRand();
  lcgState = lcgState * 32'd1103515245 + 32'd12345;
  return lcgState[30:15];
endfunction

// Odd codes are the complements of the even code below them.
function automatic logic condHolds(codeT code, astatT s);
  logic neg;
  logic base;
  neg = s.an ^ s.av; // True sign of the result, corrected for overflow.
  case (code[3:1])
    3'd0:    base = s.az;
    3'd1:    base = !(neg || s.az);
    3'd2:    base = neg;
    3'd3:    base = s.av;
    3'd4:    base = s.ac;
    3'd5:    base = s.as;
    3'd6:    base = s.mv;
    default: base = 1'b0; // There is no loop counter to expire.
  endcase
  return base ^ code[0];
endfunction

`endif

/* dv/dspStatusTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dspStatusTb
  import dspStatusPkg::*;
();

  localparam int STACK_DEPTH    = 4;
  localparam int WAIT_LIMIT     = 40;
  localparam int RESULT_NEGEDGE = 3; // Negedge after the drive edge where an op's result shows.

  // One expected result beat.
  typedef struct packed {
    dataT        data;
    logic        hasData; // Only ALU kinds produce a result word.
    logic        cond;
    logic        term;
    astatT       astat;
    logic [31:0] due;
  } expT;

  logic     DSPCLK;
  logic     T_RSTi;
  logic     opValid;
  opKindT   opKind;
  dataT     opA;
  dataT     opB;
  codeT     opCond;
  codeT     opTerm;
  logic     resValid;
  dataT     resData;
  logic     condOk;
  logic     termOk;
  astatT    astat;
  logic     wbCyc;
  logic     wbStb;
  logic     wbWe;
  hostAdrT  wbAdr;
  hostDataT wbDatW;
  hostDataT wbDatR;
  logic     wbAck;

  astatT       modelAstat;
  astatT       stackModel[$];
  logic        stickyModel;
  logic        ovfModel;
  logic        udfModel;
  expT         expQ[$];
  int unsigned negCnt;
  int          checkCount;
  int          errCount;
  int          ackCycles;
  int          opsAtAck;
  logic [31:0] lcgState;

  `include "dspStatusChecks.svh"

  dspStatusTop #(.STACK_DEPTH(STACK_DEPTH)) dut0 (.*);

  initial begin
    DSPCLK = 1'b0;
    forever #50 DSPCLK = ~DSPCLK;
  end

  task automatic abortRun(string what);
    $display("Timeout: %s", what);
    $display("Checks: %0d, errors: %0d", checkCount, errCount + 1);
    $display("TEST FAILED");
    $finish;
  endtask

  // Steps the model of ASTAT, stack and sticky mode by one operation.
  function automatic expT modelOp(opKindT kind, dataT a, dataT b, codeT cond, codeT term);
    expT   e;
    astatT s;
    int    sa;
    int    sb;
    int    wide;
    logic  carry;
    e     = '0;
    s     = modelAstat;
    sa    = $signed(a);
    sb    = $signed(b);
    wide  = 0;
    carry = 1'b0;
    case (kind)
      ADD: begin
        wide  = sa + sb;
        carry = (int'(a) + int'(b)) > 65535;
      end
      SUB: begin
        wide  = sa - sb;
        carry = (a >= b); // Carry means no borrow.
      end
      ABS: begin
        wide = (sa < 0) ? -sa : sa;
        s.as = (sa < 0);
      end
      PASS: wide = sa;
      PUSH: begin
        if (stackModel.size() == STACK_DEPTH) ovfModel = 1'b1;
        else stackModel.push_back(modelAstat);
      end
      POP: begin
        if (stackModel.size() == 0) udfModel = 1'b1;
        else s = stackModel.pop_back();
      end
      default: ;
    endcase
    if (kind inside {ADD, SUB, ABS, PASS}) begin
      e.hasData = 1'b1;
      e.data    = dataT'(wide);
      s.az      = (e.data == '0);
      s.an      = e.data[15];
      s.ac      = carry;
      s.av      = (wide > 32767) || (wide < -32768) || (stickyModel && modelAstat.av);
    end
    e.cond     = condHolds(cond, s);
    e.term     = (term == ALWAYS) ? 1'b0 : !condHolds(term, s);
    e.astat    = s;
    modelAstat = s;
    return e;
  endfunction

  task automatic issueOp(opKindT kind, dataT a, dataT b, codeT cond, codeT term);
    expT e;
    @(posedge DSPCLK);
    opValid <= 1'b1;
    opKind  <= kind;
    opA     <= a;
    opB     <= b;
    opCond  <= cond;
    opTerm  <= term;
    e     = modelOp(kind, a, b, cond, term);
    e.due = negCnt + 2; // The result is registered two edges after this one.
    expQ.push_back(e);
  endtask

  task automatic stopOps();
    @(posedge DSPCLK);
    opValid <= 1'b0;
  endtask

  task automatic drainOps();
    int n;
    stopOps();
    n = 0;
    while (expQ.size() != 0 && n < WAIT_LIMIT) begin
      @(posedge DSPCLK);
      n++;
    end
    if (expQ.size() != 0) abortRun("operation results stopped arriving");
  endtask

  task automatic hostAccess(logic we, hostAdrT adr, hostDataT dat, output hostDataT rd);
    int n;
    @(posedge DSPCLK);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= we;
    wbAdr  <= adr;
    wbDatW <= dat;
    n = 0;
    do begin
      @(negedge DSPCLK);
      n++;
    end while (!wbAck && n < WAIT_LIMIT);
    if (!wbAck) begin
      abortRun("no wbAck for a host access");
    end else begin
      rd        = wbDatR;
      ackCycles = n;
      opsAtAck  = expQ.size();
      @(posedge DSPCLK);
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
    end
  endtask

  task automatic writeReg(hostAdrT adr, hostDataT dat);
    hostDataT rd;
    hostAccess(1'b1, adr, dat, rd);
    case (adr)
      ADR_ASTAT: modelAstat = astatT'(dat);
      ADR_CTRL:  stickyModel = dat[0];
      ADR_STACK: begin
        if (dat[0]) begin
          ovfModel = 1'b0;
          udfModel = 1'b0;
        end
      end
      default: ;
    endcase
  endtask

  task automatic readReg(hostAdrT adr);
    hostDataT rd;
    hostDataT stackByte;
    stackByte = {udfModel, ovfModel, 2'b00, 4'(stackModel.size())};
    hostAccess(1'b0, adr, '0, rd);
    case (adr)
      ADR_ASTAT: compareStatus("wbDatR ASTAT", astatT'(rd), modelAstat);
      ADR_CTRL:  compareByte("wbDatR CTRL", rd, {7'd0, stickyModel});
      default:   compareByte("wbDatR STACK", rd, stackByte);
    endcase
  endtask

  // Each result beat is checked mid-cycle, where the registered outputs are stable.
  always @(negedge DSPCLK) begin
    expT e;
    if (!T_RSTi && resValid) begin
      if (expQ.size() == 0) begin
        errCount++;
        $display("Unexpected result: resValid high at %0t ns with nothing outstanding", $time);
      end else begin
        e = expQ.pop_front();
        checkCount++;
        if (e.due != negCnt) begin
          errCount++;
          $display("[FAIL] %0t ns result cycle got %0d expected %0d", $time, negCnt, e.due);
        end
        if (e.hasData) compareWord("resData", resData, e.data);
        compareBit("condOk", condOk, e.cond);
        compareBit("termOk", termOk, e.term);
        compareStatus("astat", astat, e.astat);
      end
    end
    negCnt++;
  end

  initial begin
    opKindT      kinds [4];
    logic [15:0] r;
    kinds       = '{ADD, SUB, ABS, PASS};
    lcgState    = 32'd8941;
    modelAstat  = '0;
    stickyModel = 1'b0;
    ovfModel    = 1'b0;
    udfModel    = 1'b0;
    negCnt      = 0;
    checkCount  = 0;
    errCount    = 0;
    T_RSTi      = 1'b1;
    opValid     = 1'b0;
    opKind      = NOP;
    opA         = '0;
    opB         = '0;
    opCond      = '0;
    opTerm      = '0;
    wbCyc       = 1'b0;
    wbStb       = 1'b0;
    wbWe        = 1'b0;
    wbAdr       = '0;
    wbDatW      = '0;
    repeat (10) @(posedge DSPCLK);
    T_RSTi <= 1'b0;

    for (int i = 0; i < 200; i++) begin
      r = nextRand();
      issueOp(kinds[r[15:14]], nextRand(), nextRand(), codeT'(r[7:4]), codeT'(r[3:0]));
    end
    issueOp(ADD, 16'h7FFF, 16'h0001, GT, LT);
    issueOp(ABS, 16'h8000, 16'h0000, AVS, ASS);
    issueOp(SUB, 16'h0000, 16'h0001, ACS, ACC);
    issueOp(PASS, 16'h0000, 16'hFFFF, EQ, NE);
    drainOps();

    // NOP leaves ASTAT alone, so the codes see the written flags.
    for (int code = 0; code < 16; code++) begin
      for (int k = 0; k < 4; k++) begin
        r = nextRand();
        writeReg(ADR_ASTAT, r[7:0]);
        issueOp(NOP, 16'h0000, 16'h0000, codeT'(code), codeT'(code));
        drainOps();
      end
    end

    writeReg(ADR_ASTAT, 8'hE0);
    readReg(ADR_ASTAT);
    issueOp(NOP, 16'h0000, 16'h0000, MVS, MVC);
    drainOps();
    writeReg(ADR_ASTAT, 8'h05);
    issueOp(NOP, 16'h0000, 16'h0000, MVS, MVC);
    drainOps();
    fork
      begin
        issueOp(ADD, 16'h1234, 16'h4321, MVC, ALWAYS);
        stopOps();
      end
      writeReg(ADR_ASTAT, 8'hC5);
    join
    checkCount++;
    if (opsAtAck != 0 || ackCycles <= RESULT_NEGEDGE) begin
      errCount++;
      $display("ASTAT write at %0t ns was acked while the E stage was busy", $time);
    end
    readReg(ADR_ASTAT);

    writeReg(ADR_CTRL, 8'h01);
    readReg(ADR_CTRL);
    issueOp(ADD, 16'h7FFF, 16'h0001, AVS, AVC);
    issueOp(ADD, 16'h0001, 16'h0001, AVS, AVC);
    issueOp(SUB, 16'h0003, 16'h0001, AVS, AVC);
    drainOps();
    writeReg(ADR_CTRL, 8'h00);
    readReg(ADR_CTRL);
    issueOp(ADD, 16'h7FFF, 16'h0001, AVS, AVC);
    issueOp(ADD, 16'h0001, 16'h0001, AVS, AVC);
    drainOps();

    for (int i = 0; i <= STACK_DEPTH; i++) begin
      r = nextRand();
      writeReg(ADR_ASTAT, r[7:0]);
      issueOp(PUSH, 16'h0000, 16'h0000, ALWAYS, ALWAYS);
      drainOps();
      readReg(ADR_STACK); // The last push overflows.
    end
    for (int i = 0; i <= STACK_DEPTH; i++) begin
      issueOp(POP, 16'h0000, 16'h0000, EQ, GE);
    end
    drainOps();
    readReg(ADR_STACK);
    readReg(ADR_ASTAT);
    writeReg(ADR_STACK, 8'h01);
    readReg(ADR_STACK);
    writeReg(ADR_ASTAT, 8'h5A);
    issueOp(PUSH, 16'h0000, 16'h0000, ACS, ACC);
    issueOp(SUB, 16'h0001, 16'h0002, LT, GE);
    issueOp(POP, 16'h0000, 16'h0000, ASS, ASC);
    drainOps();
    readReg(ADR_STACK);
    readReg(ADR_ASTAT);

    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+dv
logic/dspStatusPkg.sv
logic/aluFlagGen.sv
logic/statusStack.sv
logic/astatHostRegs.sv
logic/condUnit.sv
logic/dspStatusTop.sv
dv/dspStatusTb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the status unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module dspStatusTb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
